// ==== rtl/rdn_pkg.sv ====
`default_nettype none

package rdn_pkg;

  // One weight word as it is stored in external memory
  typedef logic [63:0] weight_word_t;

  localparam int WORDS_PER_LINE = 8;
  localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

  // A fetched line, slot 0 holds the word with the lowest address
  typedef weight_word_t [WORDS_PER_LINE-1:0] mem_line_t;

  localparam int NEURON_W = 8;
  localparam int INDEX_W = 9;
  localparam int MEM_ADDR_W = 16;

  typedef enum logic [1:0] {
    LAYER_A,
    LAYER_B,
    LAYER_C
  } layer_e;

  // Weight-write bus towards the neuron arrays
  typedef struct packed {
    logic                wr;
    layer_e              layer;
    logic [NEURON_W-1:0] neuron;
    logic [INDEX_W-1:0]  index;
    weight_word_t        data;
  } weight_wr_t;

endpackage

`default_nettype wire

// ==== rtl/rdn_line_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdn_line_fetch import rdn_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  go,
  input  logic                  req_mem,
  input  weight_word_t          mem_rd_data,
  input  logic                  mem_rd_valid,
  output logic                  mem_rd_en,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output mem_line_t             mem_data,
  output logic                  mem_ready
);

  localparam int LINE_PTR_W = MEM_ADDR_W - WORD_SEL_W;
  localparam logic [WORD_SEL_W-1:0] LAST_WORD = WORD_SEL_W'(WORDS_PER_LINE - 1);

  logic                  line_start;
  logic                  issuing;
  logic [LINE_PTR_W-1:0] line_ptr;
  logic [WORD_SEL_W-1:0] issue_cnt;
  logic [WORD_SEL_W-1:0] fill_cnt;
  logic [WORD_SEL_W:0]   outstanding;
  mem_line_t             line_q;

  assign line_start = go || req_mem;
  assign mem_rd_en  = issuing;
  assign mem_addr   = {line_ptr, issue_cnt};
  assign mem_data   = line_q;

  // Eight reads on back-to-back cycles, the line pointer moves on after the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issuing   <= 1'b0;
      issue_cnt <= '0;
      line_ptr  <= '0;
    end else begin
      if (go) begin
        line_ptr <= '0;
      end else if (issuing && issue_cnt == LAST_WORD) begin
        line_ptr <= line_ptr + 1'b1;
      end

      if (line_start) begin
        issuing   <= 1'b1;
        issue_cnt <= '0;
      end else if (issuing) begin
        issue_cnt <= issue_cnt + 1'b1;
        if (issue_cnt == LAST_WORD) begin
          issuing <= 1'b0;
        end
      end
    end
  end

  // Returned words arrive in order, so a simple fill pointer is enough
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt  <= '0;
      mem_ready <= 1'b0;
    end else if (line_start) begin
      fill_cnt  <= '0;
      mem_ready <= 1'b0;
    end else if (mem_rd_valid) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_cnt == LAST_WORD) begin
        mem_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd_valid) begin
      line_q[fill_cnt] <= mem_rd_data;
    end
  end

  // Reads issued but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      case ({mem_rd_en, mem_rd_valid})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  a_no_stray_data: assert property (@(posedge clk) disable iff (!rst_n)
    mem_rd_valid |-> (outstanding != '0));

  // The sequencer may only ask for a line once the previous one has landed
  a_req_when_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    req_mem |-> (!issuing && outstanding == '0));

endmodule

`default_nettype wire

// ==== rtl/rdn_weight_ld.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdn_weight_ld import rdn_pkg::*; #(
  parameter int NUM_INPUTS    = 400,
  parameter int NUM_A_NEURONS = 15,
  parameter int NUM_B_NEURONS = 30,
  parameter int NUM_C_NEURONS = 36
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  logic                mem_ready,
  input  mem_line_t           mem_data,
  output weight_word_t        weight_word,
  output logic                write_a,
  output logic                write_b,
  output logic                write_c,
  output logic [NEURON_W-1:0] neuron_sel,
  output logic [INDEX_W-1:0]  weight_sel,
  output logic                weight_valid,
  output logic                req_mem
);

  // Index of the last weight of one neuron in each layer (bias included)
  localparam logic [INDEX_W-1:0] A_LAST_IDX = INDEX_W'(NUM_INPUTS);
  localparam logic [INDEX_W-1:0] B_LAST_IDX = INDEX_W'(NUM_A_NEURONS);
  localparam logic [INDEX_W-1:0] C_LAST_IDX = INDEX_W'(NUM_B_NEURONS);

  localparam logic [NEURON_W-1:0] A_LAST_NRN = NEURON_W'(NUM_A_NEURONS - 1);
  localparam logic [NEURON_W-1:0] B_LAST_NRN = NEURON_W'(NUM_B_NEURONS - 1);
  localparam logic [NEURON_W-1:0] C_LAST_NRN = NEURON_W'(NUM_C_NEURONS - 1);

  localparam logic [WORD_SEL_W-1:0] LAST_WORD = WORD_SEL_W'(WORDS_PER_LINE - 1);

  typedef enum logic [3:0] {
    IDLE,
    GET_A,
    LD_A,
    NEW_A,
    GET_B,
    LD_B,
    NEW_B,
    GET_C,
    LD_C,
    NEW_C
  } seq_state_e;

  seq_state_e state, nxt_state;

  logic                  load_start;
  logic                  ld_weight;
  logic                  capture;
  logic                  new_neuron;
  logic                  inc_a, inc_b, inc_c;
  logic [WORD_SEL_W-1:0] word_cnt;
  logic [INDEX_W-1:0]    weight_cnt;
  logic [NEURON_W-1:0]   a_cnt, b_cnt, c_cnt;
  mem_line_t             line_q;

  // A go while the FSM is busy is dropped here
  assign load_start  = go && (state == IDLE);
  assign ld_weight   = write_a || write_b || write_c;
  assign weight_word = line_q[word_cnt];
  assign weight_sel  = weight_cnt;

  always_comb begin
    case (state)
      GET_B, LD_B, NEW_B: neuron_sel = b_cnt;
      GET_C, LD_C, NEW_C: neuron_sel = c_cnt;
      default:            neuron_sel = a_cnt;
    endcase
  end

  // Word position within the current line restarts with every line request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
    end else if (load_start || req_mem) begin
      word_cnt <= '0;
    end else if (ld_weight) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // Weight position within the current neuron
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_cnt <= '0;
    end else if (load_start || new_neuron) begin
      weight_cnt <= '0;
    end else if (ld_weight) begin
      weight_cnt <= weight_cnt + 1'b1;
    end
  end

  // Neuron counters clear on go so that a repeated load starts over
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_cnt <= '0;
      b_cnt <= '0;
      c_cnt <= '0;
    end else if (load_start) begin
      a_cnt <= '0;
      b_cnt <= '0;
      c_cnt <= '0;
    end else begin
      if (inc_a) a_cnt <= a_cnt + 1'b1;
      if (inc_b) b_cnt <= b_cnt + 1'b1;
      if (inc_c) c_cnt <= c_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      line_q <= mem_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state    = state;
    capture      = 1'b0;
    new_neuron   = 1'b0;
    inc_a        = 1'b0;
    inc_b        = 1'b0;
    inc_c        = 1'b0;
    write_a      = 1'b0;
    write_b      = 1'b0;
    write_c      = 1'b0;
    weight_valid = 1'b0;
    req_mem      = 1'b0;

    case (state)
      IDLE: if (load_start) nxt_state = GET_A;

      GET_A: if (mem_ready) begin
        capture   = 1'b1;
        nxt_state = LD_A;
      end
      // Each LD cycle writes one weight and the last weight of a neuron ends the line early
      LD_A: begin
        write_a = 1'b1;
        if (weight_cnt == A_LAST_IDX) begin
          new_neuron = 1'b1;
          nxt_state  = NEW_A;
        end else if (word_cnt == LAST_WORD) begin
          req_mem   = 1'b1;
          nxt_state = GET_A;
        end
      end
      NEW_A: begin
        req_mem = 1'b1;
        if (a_cnt == A_LAST_NRN) begin
          nxt_state = GET_B;
        end else begin
          inc_a     = 1'b1;
          nxt_state = GET_A;
        end
      end

      GET_B: if (mem_ready) begin
        capture   = 1'b1;
        nxt_state = LD_B;
      end
      LD_B: begin
        write_b = 1'b1;
        if (weight_cnt == B_LAST_IDX) begin
          new_neuron = 1'b1;
          nxt_state  = NEW_B;
        end else if (word_cnt == LAST_WORD) begin
          req_mem   = 1'b1;
          nxt_state = GET_B;
        end
      end
      NEW_B: begin
        req_mem = 1'b1;
        if (b_cnt == B_LAST_NRN) begin
          nxt_state = GET_C;
        end else begin
          inc_b     = 1'b1;
          nxt_state = GET_B;
        end
      end

      GET_C: if (mem_ready) begin
        capture   = 1'b1;
        nxt_state = LD_C;
      end
      LD_C: begin
        write_c = 1'b1;
        if (weight_cnt == C_LAST_IDX) begin
          new_neuron = 1'b1;
          nxt_state  = NEW_C;
        end else if (word_cnt == LAST_WORD) begin
          req_mem   = 1'b1;
          nxt_state = GET_C;
        end
      end
      // No line request after the very last neuron
      NEW_C: begin
        if (c_cnt == C_LAST_NRN) begin
          weight_valid = 1'b1;
          nxt_state    = IDLE;
        end else begin
          req_mem   = 1'b1;
          inc_c     = 1'b1;
          nxt_state = GET_C;
        end
      end

      default: nxt_state = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rdn_weight_combine.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdn_weight_combine import rdn_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  logic                write_a,
  input  logic                write_b,
  input  logic                write_c,
  input  logic [NEURON_W-1:0] neuron_sel,
  input  logic [INDEX_W-1:0]  weight_sel,
  input  weight_word_t        weight_word,
  input  logic                weight_valid,
  output weight_wr_t          wr_bus,
  output weight_word_t        load_sig,
  output logic                load_done
);

  localparam int SIG_W = $bits(weight_word_t);

  logic                any_write;
  layer_e              layer_in;
  logic                wr_q;
  layer_e              layer_q;
  logic [NEURON_W-1:0] neuron_q;
  logic [INDEX_W-1:0]  index_q;
  weight_word_t        data_q;
  weight_word_t        sig_q;

  assign any_write = write_a || write_b || write_c;

  // The strobes are one-hot, so a simple priority encode gives the layer
  always_comb begin
    if (write_c) begin
      layer_in = LAYER_C;
    end else if (write_b) begin
      layer_in = LAYER_B;
    end else begin
      layer_in = LAYER_A;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q      <= 1'b0;
      load_done <= 1'b0;
    end else begin
      wr_q      <= any_write;
      load_done <= weight_valid;
    end
  end

  // Payload only moves with a write and holds between writes
  always_ff @(posedge clk) begin
    if (any_write) begin
      layer_q  <= layer_in;
      neuron_q <= neuron_sel;
      index_q  <= weight_sel;
      data_q   <= weight_word;
    end
  end

  // The signature rotates left by one and takes in the written word in step with the bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sig_q <= '0;
    end else if (go) begin
      sig_q <= '0;
    end else if (any_write) begin
      sig_q <= {sig_q[SIG_W-2:0], sig_q[SIG_W-1]} ^ weight_word;
    end
  end

  assign wr_bus = '{wr: wr_q, layer: layer_q, neuron: neuron_q, index: index_q, data: data_q};
  assign load_sig = sig_q;

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({write_a, write_b, write_c}));

endmodule

`default_nettype wire

// ==== rtl/rdn_weight_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdn_weight_loader import rdn_pkg::*; #(
  parameter int NUM_INPUTS    = 400,
  parameter int NUM_A_NEURONS = 15,
  parameter int NUM_B_NEURONS = 30,
  parameter int NUM_C_NEURONS = 36
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  go,
  input  weight_word_t          mem_rd_data,
  input  logic                  mem_rd_valid,
  output logic                  mem_rd_en,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output weight_wr_t            wr_bus,
  output weight_word_t          load_sig,
  output logic                  load_done
);

  logic                load_busy;
  logic                start;
  logic                req_mem;
  logic                mem_ready;
  mem_line_t           mem_data;
  weight_word_t        weight_word;
  logic                write_a, write_b, write_c;
  logic [NEURON_W-1:0] neuron_sel;
  logic [INDEX_W-1:0]  weight_sel;
  logic                weight_valid;

  // A go during a running load must not restart the fetcher or clear the signature
  assign start = go && !load_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_busy <= 1'b0;
    end else if (start) begin
      load_busy <= 1'b1;
    end else if (weight_valid) begin
      load_busy <= 1'b0;
    end
  end

  rdn_line_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .go           (start),
    .req_mem      (req_mem),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_en    (mem_rd_en),
    .mem_addr     (mem_addr),
    .mem_data     (mem_data),
    .mem_ready    (mem_ready)
  );

  rdn_weight_ld #(
    .NUM_INPUTS    (NUM_INPUTS),
    .NUM_A_NEURONS (NUM_A_NEURONS),
    .NUM_B_NEURONS (NUM_B_NEURONS),
    .NUM_C_NEURONS (NUM_C_NEURONS)
  ) u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .go           (start),
    .mem_ready    (mem_ready),
    .mem_data     (mem_data),
    .weight_word  (weight_word),
    .write_a      (write_a),
    .write_b      (write_b),
    .write_c      (write_c),
    .neuron_sel   (neuron_sel),
    .weight_sel   (weight_sel),
    .weight_valid (weight_valid),
    .req_mem      (req_mem)
  );

  rdn_weight_combine u_combine (
    .clk          (clk),
    .rst_n        (rst_n),
    .go           (start),
    .write_a      (write_a),
    .write_b      (write_b),
    .write_c      (write_c),
    .neuron_sel   (neuron_sel),
    .weight_sel   (weight_sel),
    .weight_word  (weight_word),
    .weight_valid (weight_valid),
    .wr_bus       (wr_bus),
    .load_sig     (load_sig),
    .load_done    (load_done)
  );

endmodule

`default_nettype wire

// ==== verification/rdn_load_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rdn_load_checker import rdn_pkg::*; #(
  parameter int NUM_INPUTS    = 400,
  parameter int NUM_A_NEURONS = 15,
  parameter int NUM_B_NEURONS = 30,
  parameter int NUM_C_NEURONS = 36,
  parameter int MEM_WORDS     = 256
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         go,
  input  logic         mem_rd_en,
  input  weight_wr_t   wr_bus,
  input  weight_word_t load_sig,
  input  logic         load_done,
  input  weight_word_t mem_image [MEM_WORDS],
  output int           error_count,
  output int           writes_checked,
  output int           loads_seen
);

  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int SIG_W     = $bits(weight_word_t);

  int           write_cnt;
  logic         active;
  weight_wr_t   exp_w;
  weight_word_t exp_sig;

  function automatic int neurons_in(input int l);
    case (l)
      0:       return NUM_A_NEURONS;
      1:       return NUM_B_NEURONS;
      default: return NUM_C_NEURONS;
    endcase
  endfunction

  // One weight per input of the layer, plus the bias
  function automatic int writes_per_neuron(input int l);
    case (l)
      0:       return NUM_INPUTS + 1;
      1:       return NUM_A_NEURONS + 1;
      default: return NUM_B_NEURONS + 1;
    endcase
  endfunction

  function automatic layer_e layer_of(input int l);
    case (l)
      0:       return LAYER_A;
      1:       return LAYER_B;
      default: return LAYER_C;
    endcase
  endfunction

  function automatic int total_writes();
    int sum;
    int l;
    sum = 0;
    for (l = 0; l < 3; l++) begin
      sum += neurons_in(l) * writes_per_neuron(l);
    end
    return sum;
  endfunction

  // Walks the load in order, every neuron starts on a fresh line and the
  // rest of its last line is skipped
  function automatic weight_wr_t expected_write(input int n);
    weight_wr_t               w;
    logic [MEM_IDX_W-1:0]     addr;
    int                       line;
    int                       seen;
    int                       l;
    int                       nrn;
    int                       k;
    w    = '0;
    line = 0;
    seen = 0;
    for (l = 0; l < 3; l++) begin
      for (nrn = 0; nrn < neurons_in(l); nrn++) begin
        for (k = 0; k < writes_per_neuron(l); k++) begin
          if (seen == n) begin
            addr     = MEM_IDX_W'(line * WORDS_PER_LINE + k % WORDS_PER_LINE);
            w.wr     = 1'b1;
            w.layer  = layer_of(l);
            w.neuron = NEURON_W'(nrn);
            w.index  = INDEX_W'(k);
            w.data   = mem_image[addr];
          end
          seen++;
          if (k % WORDS_PER_LINE == WORDS_PER_LINE - 1 || k == writes_per_neuron(l) - 1) begin
            line++;
          end
        end
      end
    end
    return w;
  endfunction

  function automatic weight_word_t expected_signature();
    weight_word_t sig;
    weight_wr_t   w;
    int           n;
    sig = '0;
    for (n = 0; n < total_writes(); n++) begin
      w   = expected_write(n);
      sig = {sig[SIG_W-2:0], sig[SIG_W-1]} ^ w.data;
    end
    return sig;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // Sampled on the falling edge, where the registered outputs are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      error_count    = 0;
      writes_checked = 0;
      loads_seen     = 0;
      write_cnt      = 0;
      active         = 1'b0;
    end else begin
      if (go) begin
        active = 1'b1;
      end
      if (!active && (wr_bus.wr || mem_rd_en)) begin
        $display("%0d ns: write or memory read seen while no load is running", $time);
        error_count++;
      end
      if (wr_bus.wr && active) begin
        if (write_cnt >= total_writes()) begin
          $display("%0d ns: more writes than one load holds", $time);
          error_count++;
        end else begin
          exp_w = expected_write(write_cnt);
          check_field("wr_bus.layer", 64'(wr_bus.layer), 64'(exp_w.layer));
          check_field("wr_bus.neuron", 64'(wr_bus.neuron), 64'(exp_w.neuron));
          check_field("wr_bus.index", 64'(wr_bus.index), 64'(exp_w.index));
          check_field("wr_bus.data", wr_bus.data, exp_w.data);
        end
        write_cnt++;
        writes_checked++;
      end
      if (load_done) begin
        if (!active) begin
          $display("%0d ns: load_done pulsed with no load running", $time);
          error_count++;
        end
        if (write_cnt != total_writes()) begin
          $display("%0d ns: load ended after %0d writes instead of %0d", $time, write_cnt,
                   total_writes());
          error_count++;
        end
        exp_sig = expected_signature();
        check_field("load_sig", load_sig, exp_sig);
        loads_seen++;
        write_cnt = 0;
        active    = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_rdn_weight_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rdn_weight_loader import rdn_pkg::*; ();

  localparam int NUM_INPUTS    = 20;
  localparam int NUM_A_NEURONS = 3;
  localparam int NUM_B_NEURONS = 4;
  localparam int NUM_C_NEURONS = 5;
  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 5;
  localparam int NUM_LOADS     = 2;
  localparam int MEM_WORDS     = 256;
  localparam int MEM_IDX_W     = $clog2(MEM_WORDS);

  // A neuron of n+1 weights spans (n+8)/8 lines
  localparam int TOTAL_WRITES = NUM_A_NEURONS * (NUM_INPUTS + 1)
                              + NUM_B_NEURONS * (NUM_A_NEURONS + 1)
                              + NUM_C_NEURONS * (NUM_B_NEURONS + 1);
  localparam int TOTAL_LINES  = NUM_A_NEURONS * ((NUM_INPUTS + 8) / 8)
                              + NUM_B_NEURONS * ((NUM_A_NEURONS + 8) / 8)
                              + NUM_C_NEURONS * ((NUM_B_NEURONS + 8) / 8);
  localparam int MARGIN_NS    = 400 * CLK_PERIOD;
  localparam int WATCHDOG_NS  = (TOTAL_WRITES + TOTAL_LINES * 12) * NUM_LOADS * CLK_PERIOD
                              + MARGIN_NS;

  logic                  clk;
  logic                  rst_n;
  logic                  go;
  weight_word_t          mem_rd_data = '0;
  logic                  mem_rd_valid = 1'b0;
  logic                  mem_rd_en;
  logic [MEM_ADDR_W-1:0] mem_addr;
  weight_wr_t            wr_bus;
  weight_word_t          load_sig;
  logic                  load_done;

  weight_word_t mem [MEM_WORDS];
  integer       seed = 35;
  int           tb_errors = 0;
  int           chk_errors;
  int           writes_checked;
  int           loads_seen;
  int           cycle = 0;
  int           last_due = 0;
  int           due;
  int           due_q[$];
  weight_word_t data_q[$];

  rdn_weight_loader #(
    .NUM_INPUTS    (NUM_INPUTS),
    .NUM_A_NEURONS (NUM_A_NEURONS),
    .NUM_B_NEURONS (NUM_B_NEURONS),
    .NUM_C_NEURONS (NUM_C_NEURONS)
  ) u_rdn_weight_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .go           (go),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_en    (mem_rd_en),
    .mem_addr     (mem_addr),
    .wr_bus       (wr_bus),
    .load_sig     (load_sig),
    .load_done    (load_done)
  );

  rdn_load_checker #(
    .NUM_INPUTS    (NUM_INPUTS),
    .NUM_A_NEURONS (NUM_A_NEURONS),
    .NUM_B_NEURONS (NUM_B_NEURONS),
    .NUM_C_NEURONS (NUM_C_NEURONS),
    .MEM_WORDS     (MEM_WORDS)
  ) u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .go             (go),
    .mem_rd_en      (mem_rd_en),
    .wr_bus         (wr_bus),
    .load_sig       (load_sig),
    .load_done      (load_done),
    .mem_image      (mem),
    .error_count    (chk_errors),
    .writes_checked (writes_checked),
    .loads_seen     (loads_seen)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Memory answers in order, each read 1 to 3 cycles after it was issued
  always @(posedge clk) begin
    #2;
    cycle++;
    mem_rd_valid = 1'b0;
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      due          = due_q.pop_front();
      mem_rd_data  = data_q.pop_front();
      mem_rd_valid = 1'b1;
    end
    if (mem_rd_en) begin
      if (mem_addr[MEM_ADDR_W-1:MEM_IDX_W] != '0) begin
        $display("%0d ns: read address 0x%h lies outside the memory model", $time, mem_addr);
        tb_errors++;
      end
      due = cycle + 1 + ({$random(seed)} % 3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      due_q.push_back(due);
      data_q.push_back(mem[mem_addr[MEM_IDX_W-1:0]]);
    end
  end

  task automatic fill_memory();
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[MEM_IDX_W'(i)] = {$random(seed), $random(seed)};
    end
  endtask

  task automatic pulse_go();
    @(posedge clk);
    #2;
    go = 1'b1;
    @(posedge clk);
    #2;
    go = 1'b0;
  endtask

  task automatic wait_load_done();
    do begin
      @(posedge clk);
      #2;
    end while (!load_done);
  endtask

  task automatic report_counts();
    $display("errors: %0d checker, %0d testbench; writes checked %0d, loads done %0d",
             chk_errors, tb_errors, writes_checked, loads_seen);
  endtask

  initial begin
    int load;
    rst_n = 1'b0;
    go    = 1'b0;
    fill_memory();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Quiet stretch so the checker sees an idle bus before the first go
    repeat (10) @(posedge clk);
    for (load = 0; load < NUM_LOADS; load++) begin
      pulse_go();
      // This go lands inside the running load and must be ignored
      repeat (40 + 13 * load) @(posedge clk);
      pulse_go();
      wait_load_done();
      repeat (8) @(posedge clk);
    end
    if (loads_seen != NUM_LOADS) begin
      $display("checker saw %0d completed loads instead of %0d", loads_seen, NUM_LOADS);
      tb_errors++;
    end
    report_counts();
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the loads did not finish within %0d ns", WATCHDOG_NS);
    report_counts();
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/rdn_pkg.sv
rtl/rdn_line_fetch.sv
rtl/rdn_weight_ld.sv
rtl/rdn_weight_combine.sv
rtl/rdn_weight_loader.sv
verification/rdn_load_checker.sv
verification/tb_rdn_weight_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the run from its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rdn_weight_loader -f verilog.f -o tb_rdn_weight_loader || exit 1
out=$(./obj_dir/tb_rdn_weight_loader)
echo "$out"
echo "$out" | grep -q "^Test passed$" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
